// File: hw/bridge_pkg.sv
/* bridge constants
   instruction field positions, port widths and pulse timing for the PIO bridge */

package bridge_pkg;

    // ==================================================
    // instruction word layout
    // ==================================================
    localparam int instr_w   = 32;      // full PIO command word

    localparam int algo_lsb  = 0;       // scaling algorithm select
    localparam int algo_w    = 2;

    localparam int zoom_lsb  = 2;       // zoom factor select
    localparam int zoom_w    = 2;

    localparam int write_bit = 4;       // 1 = pixel write, 0 = resize job

    localparam int addr_lsb  = 5;       // pixel address, bits 19..5
    localparam int addr_w    = 15;

    localparam int pixel_lsb = 20;      // pixel data, bits 27..20
    localparam int pixel_w   = 8;

    // bits 31..28 unused by the scaler

    // ==================================================
    // board i/o widths
    // ==================================================
    localparam int key_count = 4;       // push buttons, active low
    localparam int sw_count  = 10;      // slide switches
    localparam int led_count = 10;      // red status lights
    localparam int trace_w   = 28;      // hw event word for the trace macrocell

    // ==================================================
    // timing
    // ==================================================
    localparam int debounce_cycles = 64;    // steady cycles before a key flips
    localparam int debounce_cnt_w  = 6;     // counts 0..63

    // reset request stretch lengths in clocks
    localparam int cold_stretch  = 6;
    localparam int warm_stretch  = 2;
    localparam int debug_stretch = 32;
    localparam int stretch_cnt_w = 6;       // must hold debug_stretch

endpackage

// File: hw/key_debounce.sv
/* key debouncer
   one counter per push button, clean value flips after a long steady disagreement */

`timescale 1ns/10ps

module key_debounce import bridge_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 reset_d,      // async, active low
    input  logic [key_count-1:0] keys_raw,     // straight from the pins
    output logic [key_count-1:0] keys_clean
);

    // ==================================================
    // per key filter
    // ==================================================
    genvar k;
    generate
        for (k = 0; k < key_count; k++) begin : g_key
            logic [debounce_cnt_w-1:0] cnt;     // consecutive disagreeing samples
            logic                      differs;

            assign differs = keys_raw[k] ^ keys_clean[k];

            always_ff @(posedge CLOCK_50 or negedge reset_d) begin
                if (!reset_d) begin
                    cnt           <= '0;
                    keys_clean[k] <= 1'b1;      // released, keys are active low
                end else if (!differs) begin
                    cnt <= '0;                  // bounce back, start over
                end else if (cnt == debounce_cnt_w'(debounce_cycles - 1)) begin
                    // last of the steady samples, accept the new level
                    keys_clean[k] <= keys_raw[k];
                    cnt           <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    endgenerate

    // a key that chatters never reaches the terminal count
    // so keys_clean holds its old value through the bounce

endmodule

// File: hw/reset_request_pulser.sv
/* reset request pulser
   rising edge on the request gives a pulse stretch_len clocks wide, busy edges ignored */

`timescale 1ns/10ps

module reset_request_pulser import bridge_pkg::*; #(
    parameter int stretch_len = 2           // pulse width in clocks
) (
    input  logic CLOCK_50,
    input  logic reset_d,                   // async, active low
    input  logic request,                   // level request from the processor side
    output logic pulse                      // stretched request to the HPS reset manager
);

    logic                     request_q;    // last sample for edge detect
    logic                     rise;
    logic [stretch_cnt_w-1:0] remaining;    // clocks of pulse still to go
    logic                     busy;

    // ==================================================
    // edge detect
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d)
            request_q <= 1'b0;
        else
            request_q <= request;
    end

    assign rise = request & ~request_q;
    assign busy = (remaining != '0);

    // ==================================================
    // stretch counter
    // ==================================================
    // loaded on the edge, so the pulse starts the next clock
    // and lasts exactly stretch_len clocks
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d) begin
            remaining <= '0;
        end else if (busy) begin
            remaining <= remaining - 1'b1;  // new edges ignored while running
        end else if (rise) begin
            remaining <= stretch_cnt_w'(stretch_len);
        end
    end

    assign pulse = busy;                    // straight off the counter flops

endmodule

// File: hw/hps_command_port.sv
/* HPS command port
   decodes the PIO instruction, starts scaler jobs, keeps done flags, drives LEDs and trace */

`timescale 1ns/10ps

module hps_command_port import bridge_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 reset_d,           // async, active low

    // processor side
    input  logic [instr_w-1:0]   pio_instruction,
    input  logic                 pio_start,         // one clock per command
    output logic                 pio_done,          // resize ready, sticky
    output logic                 pio_done_write,    // pixel write ready, sticky

    // scaler side
    input  logic                 redim_done,        // one clock pulse
    input  logic                 write_done,        // one clock pulse
    output logic [algo_w-1:0]    algorithm_sel,
    output logic [zoom_w-1:0]    zoom_sel,
    output logic [addr_w-1:0]    pixel_addr,
    output logic [pixel_w-1:0]   pixel_data,
    output logic                 write_req,
    output logic                 redim_go,
    output logic                 write_go,

    // board
    input  logic [key_count-1:0] keys_clean,
    input  logic [sw_count-1:0]  sw,
    output logic [led_count-1:0] ledr,
    output logic [trace_w-1:0]   stm_hw_events
);

    // ==================================================
    // instruction slices
    // ==================================================
    logic [algo_w-1:0]  instr_algo;
    logic [zoom_w-1:0]  instr_zoom;
    logic               instr_write;
    logic [addr_w-1:0]  instr_addr;
    logic [pixel_w-1:0] instr_pixel;
    logic               start_redim;        // start of a resize job
    logic               start_write;        // start of a pixel write

    assign instr_algo  = pio_instruction[algo_lsb +: algo_w];
    assign instr_zoom  = pio_instruction[zoom_lsb +: zoom_w];
    assign instr_write = pio_instruction[write_bit];
    assign instr_addr  = pio_instruction[addr_lsb +: addr_w];
    assign instr_pixel = pio_instruction[pixel_lsb +: pixel_w];

    assign start_redim = pio_start & ~instr_write;
    assign start_write = pio_start &  instr_write;

    // ==================================================
    // field capture and go pulses
    // ==================================================
    // no back pressure, a new start simply overwrites
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d) begin
            algorithm_sel <= '0;
            zoom_sel      <= '0;
            pixel_addr    <= '0;
            pixel_data    <= '0;
            write_req     <= 1'b0;
        end else if (pio_start) begin
            algorithm_sel <= instr_algo;
            zoom_sel      <= instr_zoom;
            pixel_addr    <= instr_addr;
            pixel_data    <= instr_pixel;
            write_req     <= instr_write;
        end
    end

    // one clock wide, aligned with the new fields
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d) begin
            redim_go <= 1'b0;
            write_go <= 1'b0;
        end else begin
            redim_go <= start_redim;
            write_go <= start_write;
        end
    end

    // ==================================================
    // done flags
    // ==================================================
    // start has priority over a done in the same clock
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d) begin
            pio_done       <= 1'b1;         // ready out of reset
            pio_done_write <= 1'b1;
        end else begin
            if (start_redim)
                pio_done <= 1'b0;
            else if (redim_done)
                pio_done <= 1'b1;

            if (start_write)
                pio_done_write <= 1'b0;
            else if (write_done)
                pio_done_write <= 1'b1;
        end
    end

    // ==================================================
    // status lights and trace word
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge reset_d) begin
        if (!reset_d) begin
            ledr          <= {{pixel_w{1'b0}}, 2'b11};    // both flags ready
            stm_hw_events <= {{(trace_w - key_count - 2){1'b0}}, 2'b11, {key_count{1'b1}}};
        end else begin
            ledr          <= {pixel_data, pio_done_write, pio_done};
            // pad, switches, lights, keys
            stm_hw_events <= {{(trace_w - sw_count - led_count - key_count){1'b0}},
                              sw, ledr, keys_clean};
        end
    end

endmodule

// File: hw/pixel_pio_bridge.sv
/* pixel PIO bridge top
   fabric logic around the HPS command word, key filters and reset request pulsers */

`timescale 1ns/10ps

module pixel_pio_bridge import bridge_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 reset_d,           // async, active low

    // board i/o
    input  logic [key_count-1:0] KEY,               // active low buttons
    input  logic [sw_count-1:0]  SW,
    output logic [led_count-1:0] LEDR,

    // HPS parallel i/o
    input  logic [instr_w-1:0]   pio_instruction,
    input  logic                 pio_start,
    output logic                 pio_done,
    output logic                 pio_done_write,

    // scaling unit
    input  logic                 redim_done,
    input  logic                 write_done,
    output logic [algo_w-1:0]    algorithm_sel,
    output logic [zoom_w-1:0]    zoom_sel,
    output logic [addr_w-1:0]    pixel_addr,
    output logic [pixel_w-1:0]   pixel_data,
    output logic                 write_req,
    output logic                 redim_go,
    output logic                 write_go,

    // HPS trace and reset requests
    output logic [trace_w-1:0]   stm_hw_events,
    input  logic                 cold_req,
    input  logic                 warm_req,
    input  logic                 debug_req,
    output logic                 hps_cold_reset,
    output logic                 hps_warm_reset,
    output logic                 hps_debug_reset
);

    logic [key_count-1:0] keys_clean;   // filtered buttons

    // ==================================================
    // push buttons
    // ==================================================
    key_debounce u_key_debounce (
        .CLOCK_50   (CLOCK_50),
        .reset_d    (reset_d),
        .keys_raw   (KEY),
        .keys_clean (keys_clean)
    );

    // ==================================================
    // command port
    // ==================================================
    hps_command_port u_command_port (
        .CLOCK_50        (CLOCK_50),
        .reset_d         (reset_d),
        .pio_instruction (pio_instruction),
        .pio_start       (pio_start),
        .pio_done        (pio_done),
        .pio_done_write  (pio_done_write),
        .redim_done      (redim_done),
        .write_done      (write_done),
        .algorithm_sel   (algorithm_sel),
        .zoom_sel        (zoom_sel),
        .pixel_addr      (pixel_addr),
        .pixel_data      (pixel_data),
        .write_req       (write_req),
        .redim_go        (redim_go),
        .write_go        (write_go),
        .keys_clean      (keys_clean),
        .sw              (SW),
        .ledr            (LEDR),
        .stm_hw_events   (stm_hw_events)
    );

    // ==================================================
    // reset request stretchers
    // ==================================================
    reset_request_pulser #(
        .stretch_len (cold_stretch)     // 6 clocks
    ) u_pulse_cold (
        .CLOCK_50 (CLOCK_50),
        .reset_d  (reset_d),
        .request  (cold_req),
        .pulse    (hps_cold_reset)
    );

    reset_request_pulser #(
        .stretch_len (warm_stretch)     // 2 clocks
    ) u_pulse_warm (
        .CLOCK_50 (CLOCK_50),
        .reset_d  (reset_d),
        .request  (warm_req),
        .pulse    (hps_warm_reset)
    );

    // debug reset needs the longest hold
    reset_request_pulser #(
        .stretch_len (debug_stretch)
    ) u_pulse_debug (
        .CLOCK_50 (CLOCK_50),
        .reset_d  (reset_d),
        .request  (debug_req),
        .pulse    (hps_debug_reset)
    );

endmodule

// File: bench/bridge_tests.svh
/* bridge directed tests
   reset state, resize and write jobs, reset request stretch, key filter and trace word */

`ifndef BRIDGE_TESTS_SVH
`define BRIDGE_TESTS_SVH

    // ==================================================
    // command port
    // ==================================================
    task automatic test_reset_state();
        int start_errors;
        start_errors = errors;
        @(negedge CLOCK_50);
        if (pio_done !== 1'b1) value_error("pio_done", 1, pio_done);
        if (pio_done_write !== 1'b1) value_error("pio_done_write", 1, pio_done_write);
        if (LEDR !== 10'b11) value_error("LEDR", 10'b11, LEDR);     // only the ready flags
        if (redim_go !== 1'b0) value_error("redim_go", 0, redim_go);
        if (write_go !== 1'b0) value_error("write_go", 0, write_go);
        if ({hps_cold_reset, hps_warm_reset, hps_debug_reset} !== 3'b000)
            report_failure("a reset request pulse is high after reset");
        if ({algorithm_sel, zoom_sel, pixel_addr, pixel_data, write_req} !== '0)
            report_failure("captured fields are not zero after reset");
        // pad, switches 0, ready flags, keys released
        if (stm_hw_events !== {4'b0, 10'd0, 10'b11, 4'hF})
            value_error("stm_hw_events", {4'b0, 10'd0, 10'b11, 4'hF}, stm_hw_events);
        end_test("reset state", start_errors);
    endtask

    task automatic test_resize_job();
        int          start_errors;
        logic [1:0]  algo;
        logic [1:0]  zoom;
        start_errors = errors;
        algo = 2'(random_bits(2));
        zoom = 2'(random_bits(2));
        pio_instruction = make_instruction(algo, zoom, 1'b0, 15'(random_bits(15)), 8'h00);
        pio_start = 1'b1;
        @(negedge CLOCK_50);
        pio_start = 1'b0;
        if (redim_go !== 1'b1)
            report_failure("redim_go did not pulse on the cycle after pio_start");
        if (write_go !== 1'b0) value_error("write_go", 0, write_go);
        if (algorithm_sel !== algo) value_error("algorithm_sel", algo, algorithm_sel);
        if (zoom_sel !== zoom) value_error("zoom_sel", zoom, zoom_sel);
        if (write_req !== 1'b0) value_error("write_req", 0, write_req);
        if (pio_done !== 1'b0) value_error("pio_done", 0, pio_done);
        @(negedge CLOCK_50);
        if (redim_go !== 1'b0) report_failure("redim_go stayed high for more than one cycle");
        if (pio_done !== 1'b0) value_error("pio_done", 0, pio_done);   // still busy
        redim_done = 1'b1;                  // scaler answers
        @(negedge CLOCK_50);
        redim_done = 1'b0;
        if (pio_done !== 1'b1) value_error("pio_done", 1, pio_done);
        if (pio_done_write !== 1'b1) value_error("pio_done_write", 1, pio_done_write);
        end_test("resize job", start_errors);
    endtask

    task automatic test_pixel_write();
        int          start_errors;
        logic [14:0] addr;
        logic [7:0]  pixel;
        start_errors = errors;
        addr  = 15'(random_bits(15));
        pixel = 8'(random_bits(8));
        pio_instruction = make_instruction(2'(random_bits(2)), 2'(random_bits(2)), 1'b1,
                                           addr, pixel);
        pio_start = 1'b1;
        @(negedge CLOCK_50);
        pio_start = 1'b0;
        if (write_go !== 1'b1)
            report_failure("write_go did not pulse on the cycle after pio_start");
        if (redim_go !== 1'b0) value_error("redim_go", 0, redim_go);
        if (pixel_addr !== addr) value_error("pixel_addr", addr, pixel_addr);
        if (pixel_data !== pixel) value_error("pixel_data", pixel, pixel_data);
        if (write_req !== 1'b1) value_error("write_req", 1, write_req);
        if (pio_done_write !== 1'b0) value_error("pio_done_write", 0, pio_done_write);
        if (pio_done !== 1'b1) value_error("pio_done", 1, pio_done);
        @(negedge CLOCK_50);
        if (write_go !== 1'b0) report_failure("write_go stayed high for more than one cycle");
        if (LEDR[9:2] !== pixel) value_error("LEDR[9:2]", pixel, LEDR[9:2]);  // lights lag
        if (LEDR[1] !== 1'b0) value_error("LEDR[1]", 0, LEDR[1]);
        // start and done together, start wins
        pixel = 8'(random_bits(8));
        last_pixel = pixel;
        pio_instruction = make_instruction(2'b00, 2'b00, 1'b1, addr, pixel);
        pio_start  = 1'b1;
        write_done = 1'b1;
        @(negedge CLOCK_50);
        pio_start  = 1'b0;
        write_done = 1'b0;
        if (pio_done_write !== 1'b0) value_error("pio_done_write", 0, pio_done_write);
        if (write_go !== 1'b1) report_failure("write_go missing after a start with write_done");
        write_done = 1'b1;
        @(negedge CLOCK_50);
        write_done = 1'b0;
        if (pio_done_write !== 1'b1) value_error("pio_done_write", 1, pio_done_write);
        end_test("pixel write", start_errors);
    endtask

    // ==================================================
    // reset request pulsers
    // ==================================================
    task automatic drive_request(input int which, input logic level);
        case (which)
            0:       cold_req  = level;
            1:       warm_req  = level;
            default: debug_req = level;
        endcase
    endtask

    function automatic logic pulse_level(input int which);
        case (which)
            0:       return hps_cold_reset;
            1:       return hps_warm_reset;
            default: return hps_debug_reset;
        endcase
    endfunction

    // counts high cycles of one pulse, rearm puts a second edge mid pulse
    task automatic measure_pulse(input int which, input string name, input int expected_len,
            input bit rearm);
        int high_cycles;
        high_cycles = 0;
        drive_request(which, 1'b1);
        @(negedge CLOCK_50);
        if (pulse_level(which) !== 1'b1)
            report_failure($sformatf("%s did not rise on the cycle after the request", name));
        while (pulse_level(which) === 1'b1 && high_cycles < 100) begin
            high_cycles++;
            if (rearm && high_cycles == 4) drive_request(which, 1'b0);
            if (rearm && high_cycles == 6) drive_request(which, 1'b1);  // busy edge
            @(negedge CLOCK_50);
        end
        drive_request(which, 1'b0);
        if (high_cycles != expected_len)
            value_error($sformatf("%s high cycles", name), expected_len, high_cycles);
        @(negedge CLOCK_50);                // let the request low be sampled
    endtask

    task automatic test_reset_stretch();
        int start_errors;
        start_errors = errors;
        measure_pulse(0, "hps_cold_reset", 6, 1'b0);
        measure_pulse(1, "hps_warm_reset", 2, 1'b0);
        measure_pulse(2, "hps_debug_reset", 32, 1'b0);
        measure_pulse(2, "hps_debug_reset", 32, 1'b1);
        end_test("reset request stretch", start_errors);
    endtask

    // ==================================================
    // key filter and trace word
    // ==================================================
    // 64 steady samples plus one clock of trace lag
    task automatic check_trace_delay(input logic level);
        int cycles;
        cycles = 0;
        KEY[0] = level;
        do begin
            @(negedge CLOCK_50);
            cycles++;
        end while (stm_hw_events[0] !== level && cycles < 200);
        if (stm_hw_events[0] !== level)
            report_failure("key 0 never reached the trace word while held steady");
        else if (cycles != 65)
            value_error("key 0 trace delay", 65, cycles);
    endtask

    task automatic test_debounce_trace();
        int                  start_errors;
        logic [sw_count-1:0] sw_value;
        start_errors = errors;
        KEY[0] = 1'b0;                      // short press
        repeat (50) begin
            @(negedge CLOCK_50);
            if (stm_hw_events[0] !== 1'b1) value_error("stm_hw_events[0]", 1, stm_hw_events[0]);
        end
        KEY[0] = 1'b1;
        repeat (4) @(negedge CLOCK_50);
        if (stm_hw_events[0] !== 1'b1) value_error("stm_hw_events[0]", 1, stm_hw_events[0]);
        check_trace_delay(1'b0);            // long press
        check_trace_delay(1'b1);            // and release
        sw_value = sw_count'(random_bits(sw_count));
        SW = sw_value;
        repeat (2) @(negedge CLOCK_50);
        // latest pixel on top, both flags ready
        if (LEDR !== {last_pixel, 2'b11}) value_error("LEDR", {last_pixel, 2'b11}, LEDR);
        if (stm_hw_events[27:24] !== 4'b0) value_error("stm_hw_events[27:24]", 0,
                                                       stm_hw_events[27:24]);
        if (stm_hw_events[23:14] !== sw_value) value_error("stm_hw_events[23:14]", sw_value,
                                                           stm_hw_events[23:14]);
        if (stm_hw_events[13:4] !== {last_pixel, 2'b11})
            value_error("stm_hw_events[13:4]", {last_pixel, 2'b11}, stm_hw_events[13:4]);
        if (stm_hw_events[3:0] !== 4'hF) value_error("stm_hw_events[3:0]", 4'hF,
                                                     stm_hw_events[3:0]);
        end_test("debounce and trace", start_errors);
    endtask

`endif

// File: bench/tb_pixel_pio_bridge.sv
/* pixel PIO bridge testbench
   clock, reset, random fields and the directed test sequence for the bridge top */

`timescale 1ns/10ps

module tb_pixel_pio_bridge import bridge_pkg::*; ();

    localparam int clk_period   = 20;       // 50 MHz
    localparam int reset_cycles = 4;

    // rough length of each test in clocks, plus a margin for the watchdog
    localparam int test_cycles  = reset_cycles + 2          // reset state
                                + 4 + 8                     // resize job, pixel write
                                + (6 + 2 + 32 + 32 + 8)     // four stretched pulses
                                + (50 + 4 + 2 * 66 + 2);    // short press, press, release
    localparam int watchdog_time = (test_cycles + 200) * clk_period;

    // ==================================================
    // DUT signals
    // ==================================================
    logic                 CLOCK_50;
    logic                 reset_d;
    logic [key_count-1:0] KEY;
    logic [sw_count-1:0]  SW;
    logic [led_count-1:0] LEDR;
    logic [instr_w-1:0]   pio_instruction;
    logic                 pio_start, pio_done, pio_done_write;
    logic                 redim_done, write_done;
    logic [algo_w-1:0]    algorithm_sel;
    logic [zoom_w-1:0]    zoom_sel;
    logic [addr_w-1:0]    pixel_addr;
    logic [pixel_w-1:0]   pixel_data;
    logic                 write_req, redim_go, write_go;
    logic [trace_w-1:0]   stm_hw_events;
    logic                 cold_req, warm_req, debug_req;
    logic                 hps_cold_reset, hps_warm_reset, hps_debug_reset;

    int                 errors;             // failed checks over the whole run
    int                 tests_passed;
    int                 tests_failed;
    logic [15:0]        lfsr_state;
    logic [pixel_w-1:0] last_pixel;         // pixel data of the latest write

    pixel_pio_bridge dut (.*);

    initial CLOCK_50 = 1'b0;
    always #(clk_period / 2) CLOCK_50 = ~CLOCK_50;

    // ==================================================
    // helpers
    // ==================================================
    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // bits 31..28 spare, then pixel, address, write flag, zoom, algorithm
    function automatic logic [31:0] make_instruction(input logic [1:0] algo,
            input logic [1:0] zoom, input logic wr, input logic [14:0] addr,
            input logic [7:0] pixel);
        return {4'b0000, pixel, addr, wr, zoom, algo};
    endfunction

    task automatic value_error(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", name, errors - start_errors);
        end
    endtask

    `include "bridge_tests.svh"

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        lfsr_state      = 16'd12473;
        last_pixel      = '0;
        reset_d         = 1'b0;
        KEY             = '1;               // released
        SW              = '0;
        pio_instruction = '0;
        pio_start       = 1'b0;
        redim_done      = 1'b0;
        write_done      = 1'b0;
        cold_req        = 1'b0;
        warm_req        = 1'b0;
        debug_req       = 1'b0;

        repeat (reset_cycles) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        reset_d = 1'b1;

        test_reset_state();
        test_resize_job();
        test_pixel_write();
        test_reset_stretch();
        test_debounce_trace();

        $display("tests passed %0d, tests failed %0d, checks failed %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // ends a hung run
    initial begin
        #(watchdog_time);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: pixel_pio_bridge.f
+incdir+bench
hw/bridge_pkg.sv
hw/key_debounce.sv
hw/reset_request_pulser.sv
hw/hps_command_port.sv
hw/pixel_pio_bridge.sv
bench/tb_pixel_pio_bridge.sv
